//--- camCfg.f
camCfgPkg.sv
initScript.sv
i2cWriteXfer.sv
i2cReadXfer.sv
cameraConfigCtrl.sv
mipiCameraConfig.sv
tbClockGen.sv
tbSensorModel.sv
tbMipiCameraConfig.sv

//--- camCfgPkg.sv
package camCfgPkg;

	typedef logic [7:0]  slaveAddr_t;   // address byte, R/W in bit 0
	typedef logic [15:0] regAddr_t;     // sensor register
	typedef logic [7:0]  regData_t;     // register value or chip ID
	typedef logic [31:0] scriptEntry_t; // {addr, reg, data}
	typedef logic [4:0]  scriptIndex_t;
	typedef logic [7:0]  gapCount_t;

	typedef enum logic [3:0] {
		ctrlPtrStart,
		ctrlPtrWait,
		ctrlPtrGap,
		ctrlReadStart,
		ctrlReadWait,
		ctrlReadGap,
		ctrlIdCheck,
		ctrlRetryGap,
		ctrlFetch,     // table latency
		ctrlDecode,
		ctrlWriteWait,
		ctrlStepGap,   // post-write gap or wait entry
		ctrlReleased
	} ctrlState_t;

	typedef enum logic [2:0] {
		xferIdle, xferStart, xferShift, xferAck, xferStop, xferDone
	} xferState_t;

endpackage

//--- camCfg_macros.svh
`ifndef CAMCFG_MACROS_SVH
`define CAMCFG_MACROS_SVH

// sensor on the I2C bus
`define CAM_I2C_ADDR     8'h6C    // write address, read is 0x6D
`define CAM_ID_REG       16'h300B // chip ID register
`define CAM_EXPECTED_ID  8'h88

// script layout
`define DELAY_TAG        8'hAA    // address field of a wait entry
`define SCRIPT_LEN       18

// bus and sequencer timing, in CLK_400K cycles
`define BIT_PHASES       4        // one I2C bit
`define XFER_GAP         8'd3     // idle after each transfer
`define RETRY_GAP        8'd5     // idle before the ID read is repeated

// white balance gains, 14 bit
// each one goes out as upper 8 bits, then lower 6 bits
`define RED_GAIN         14'h44A
`define GREEN_GAIN       14'h4C0
`define BLUE_GAIN        14'h400

`endif

//--- cameraConfigCtrl.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module cameraConfigCtrl (
	input  logic                    CLK_400K,
	input  logic                    RESET_N,
	input  logic                    writeDone,
	input  logic                    readDone,
	input  camCfgPkg::regData_t     readData,
	input  camCfgPkg::scriptEntry_t scriptEntry,
	output logic                    writeStart,
	output camCfgPkg::slaveAddr_t   writeSlave,
	output camCfgPkg::regAddr_t     writeReg,
	output camCfgPkg::regData_t     writeData,
	output logic [1:0]              writeByteCount,
	output logic                    readStart,
	output camCfgPkg::slaveAddr_t   readSlave,
	output camCfgPkg::scriptIndex_t scriptIndex,
	output camCfgPkg::regData_t     sensorId,
	output logic                    cameraReleased
);

	camCfgPkg::ctrlState_t state;
	camCfgPkg::gapCount_t  gapCount; // counts down, shared by gaps and waits
	logic                  gapDone;
	logic                  isWait;
	logic                  lastEntry;

	assign gapDone = (gapCount <= 8'd1);
	assign isWait = (scriptEntry[31:24] == `DELAY_TAG);
	assign lastEntry = (scriptIndex == 5'(`SCRIPT_LEN - 1));

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= camCfgPkg::ctrlPtrStart;
			writeStart <= 1'b0;
			readStart <= 1'b0;
			gapCount <= '0;
			scriptIndex <= '0;
			sensorId <= '0;
			cameraReleased <= 1'b0;
		end else begin
			writeStart <= 1'b0;
			readStart <= 1'b0;
			case (state)
				// chip ID check
				camCfgPkg::ctrlPtrStart: begin
					writeStart <= 1'b1;
					state <= camCfgPkg::ctrlPtrWait;
				end
				camCfgPkg::ctrlPtrWait: begin
					if (writeDone) begin
						gapCount <= `XFER_GAP;
						state <= camCfgPkg::ctrlPtrGap;
					end
				end
				camCfgPkg::ctrlPtrGap: begin
					gapCount <= gapCount - 8'd1;
					if (gapDone) state <= camCfgPkg::ctrlReadStart;
				end
				camCfgPkg::ctrlReadStart: begin
					readStart <= 1'b1;
					state <= camCfgPkg::ctrlReadWait;
				end
				camCfgPkg::ctrlReadWait: begin
					if (readDone) begin
						sensorId <= readData; // every read lands here
						gapCount <= `XFER_GAP;
						state <= camCfgPkg::ctrlReadGap;
					end
				end
				camCfgPkg::ctrlReadGap: begin
					gapCount <= gapCount - 8'd1;
					if (gapDone) state <= camCfgPkg::ctrlIdCheck;
				end
				camCfgPkg::ctrlIdCheck: begin
					if (sensorId == `CAM_EXPECTED_ID) begin
						scriptIndex <= '0;
						state <= camCfgPkg::ctrlFetch;
					end else begin
						gapCount <= `RETRY_GAP;
						state <= camCfgPkg::ctrlRetryGap;
					end
				end
				camCfgPkg::ctrlRetryGap: begin
					gapCount <= gapCount - 8'd1;
					if (gapDone) state <= camCfgPkg::ctrlPtrStart;
				end
				// script walk
				camCfgPkg::ctrlFetch: state <= camCfgPkg::ctrlDecode; // entry registered now
				camCfgPkg::ctrlDecode: begin
					if (isWait) begin
						gapCount <= scriptEntry[7:0];
						state <= camCfgPkg::ctrlStepGap;
					end else begin
						writeStart <= 1'b1;
						state <= camCfgPkg::ctrlWriteWait;
					end
				end
				camCfgPkg::ctrlWriteWait: begin
					if (writeDone) begin
						gapCount <= `XFER_GAP;
						state <= camCfgPkg::ctrlStepGap;
					end
				end
				camCfgPkg::ctrlStepGap: begin
					gapCount <= gapCount - 8'd1;
					if (gapDone && lastEntry) begin
						cameraReleased <= 1'b1;
						state <= camCfgPkg::ctrlReleased;
					end else if (gapDone) begin
						scriptIndex <= scriptIndex + 5'd1;
						state <= camCfgPkg::ctrlFetch;
					end
				end
				camCfgPkg::ctrlReleased: state <= camCfgPkg::ctrlReleased; // until reset
				default: state <= camCfgPkg::ctrlPtrStart;
			endcase
		end
	end

	// transfer fields, loaded with the start strobe and held until done
	always_ff @(posedge CLK_400K) begin
		if (state == camCfgPkg::ctrlPtrStart) begin
			writeSlave <= `CAM_I2C_ADDR;
			writeReg <= `CAM_ID_REG;
			writeData <= '0;
			writeByteCount <= 2'd2; // pointer only
		end else if (state == camCfgPkg::ctrlDecode) begin
			writeSlave <= scriptEntry[31:24];
			writeReg <= scriptEntry[23:8];
			writeData <= scriptEntry[7:0];
			writeByteCount <= 2'd3;
		end
		if (state == camCfgPkg::ctrlReadStart) begin
			readSlave <= `CAM_I2C_ADDR;
		end
	end

endmodule

//--- i2cReadXfer.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module i2cReadXfer (
	input  logic                  CLK_400K,
	input  logic                  RESET_N,
	input  logic                  readStart,
	input  camCfgPkg::slaveAddr_t readSlave,
	input  logic                  sdaIn,
	output logic                  sclOut,
	output logic                  sdaOut,
	output logic                  readDone,
	output camCfgPkg::regData_t   readData
);

	camCfgPkg::xferState_t state;
	logic [1:0] phase;
	logic [2:0] bitCount;
	logic       dataByte; // second byte, driven by the sensor
	logic [7:0] addrShift;
	logic [7:0] shiftIn;
	logic       phaseEnd;
	logic       sclHigh;
	logic       sclNext;
	logic       sdaNext;

	assign phaseEnd = (phase == 2'(`BIT_PHASES - 1));
	assign sclHigh = (phase != 2'd0) && !phaseEnd;
	assign readDone = (state == camCfgPkg::xferDone);

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= camCfgPkg::xferIdle;
			phase <= '0;
			bitCount <= '0;
			dataByte <= 1'b0;
		end else begin
			phase <= (state == camCfgPkg::xferIdle) ? 2'd0 : phase + 2'd1;
			case (state)
				camCfgPkg::xferIdle: begin
					dataByte <= 1'b0;
					if (readStart) begin
						state <= camCfgPkg::xferStart;
					end
				end
				camCfgPkg::xferStart: begin
					if (phaseEnd) begin
						state <= camCfgPkg::xferShift;
						bitCount <= '0;
					end
				end
				camCfgPkg::xferShift: begin
					if (phaseEnd) begin
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7) begin
							state <= camCfgPkg::xferAck;
						end
					end
				end
				camCfgPkg::xferAck: begin
					if (phaseEnd) begin
						dataByte <= 1'b1;
						state <= dataByte ? camCfgPkg::xferStop : camCfgPkg::xferShift;
					end
				end
				camCfgPkg::xferStop: begin
					if (phaseEnd) begin
						state <= camCfgPkg::xferDone;
					end
				end
				default: state <= camCfgPkg::xferIdle;
			endcase
		end
	end

	always_ff @(posedge CLK_400K) begin
		if (state == camCfgPkg::xferIdle && readStart) begin
			addrShift <= {readSlave[7:1], 1'b1}; // read bit
		end else if (state == camCfgPkg::xferShift && !dataByte && phaseEnd) begin
			addrShift <= {addrShift[6:0], 1'b0};
		end
		if (state == camCfgPkg::xferShift && dataByte && phase == 2'(`BIT_PHASES / 2)) begin
			shiftIn <= {shiftIn[6:0], sdaIn}; // middle of SCL high
		end
		if (state == camCfgPkg::xferStop && phaseEnd) begin
			readData <= shiftIn;
		end
	end

	always_comb begin
		sclNext = 1'b1;
		sdaNext = 1'b1;
		case (state)
			camCfgPkg::xferStart: sdaNext = (phase < 2'(`BIT_PHASES / 2));
			camCfgPkg::xferShift: begin
				sclNext = sclHigh;
				sdaNext = dataByte ? 1'b1 : addrShift[7];
			end
			camCfgPkg::xferAck: sclNext = sclHigh; // nack after the data byte
			camCfgPkg::xferStop: begin
				sclNext = (phase != 2'd0);
				sdaNext = (phase >= 2'(`BIT_PHASES / 2));
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			sclOut <= 1'b1;
			sdaOut <= 1'b1;
		end else begin
			sclOut <= sclNext;
			sdaOut <= sdaNext;
		end
	end

endmodule

//--- i2cWriteXfer.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module i2cWriteXfer (
	input  logic                  CLK_400K,
	input  logic                  RESET_N,
	input  logic                  writeStart,
	input  camCfgPkg::slaveAddr_t writeSlave,
	input  camCfgPkg::regAddr_t   writeReg,
	input  camCfgPkg::regData_t   writeData,
	input  logic [1:0]            writeByteCount,
	input  logic                  sdaIn,
	output logic                  sclOut,
	output logic                  sdaOut,
	output logic                  writeDone
);

	camCfgPkg::xferState_t state;
	logic [1:0]  phase;
	logic [2:0]  bitCount;
	logic [2:0]  bytesLeft; // address byte included
	logic [31:0] shiftReg;
	logic        phaseEnd;
	logic        sclHigh;
	logic        sclNext;
	logic        sdaNext;

	assign phaseEnd = (phase == 2'(`BIT_PHASES - 1));
	assign sclHigh = (phase != 2'd0) && !phaseEnd; // SDA moves only while SCL is low
	assign writeDone = (state == camCfgPkg::xferDone);

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= camCfgPkg::xferIdle;
			phase <= '0;
			bitCount <= '0;
			bytesLeft <= '0;
		end else begin
			case (state)
				camCfgPkg::xferIdle: begin
					phase <= '0;
					if (writeStart) begin
						state <= camCfgPkg::xferStart;
						bytesLeft <= {1'b0, writeByteCount} + 3'd1;
					end
				end
				camCfgPkg::xferStart: begin
					if (phase != 2'd1 || sdaIn) begin // hold off while SDA is low
						phase <= phase + 2'd1;
					end
					if (phaseEnd) begin
						state <= camCfgPkg::xferShift;
						bitCount <= '0;
					end
				end
				camCfgPkg::xferShift: begin
					phase <= phase + 2'd1;
					if (phaseEnd) begin
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7) begin
							state <= camCfgPkg::xferAck;
						end
					end
				end
				camCfgPkg::xferAck: begin
					phase <= phase + 2'd1;
					if (phaseEnd) begin
						bytesLeft <= bytesLeft - 3'd1;
						state <= (bytesLeft == 3'd1) ? camCfgPkg::xferStop : camCfgPkg::xferShift;
					end
				end
				camCfgPkg::xferStop: begin
					phase <= phase + 2'd1;
					if (phaseEnd) begin
						state <= camCfgPkg::xferDone;
					end
				end
				default: state <= camCfgPkg::xferIdle; // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge CLK_400K) begin
		if (state == camCfgPkg::xferIdle && writeStart) begin
			shiftReg <= {writeSlave, writeReg, writeData};
		end else if (state == camCfgPkg::xferShift && phaseEnd) begin
			shiftReg <= {shiftReg[30:0], 1'b0}; // msb first
		end
	end

	always_comb begin
		sclNext = 1'b1;
		sdaNext = 1'b1;
		case (state)
			camCfgPkg::xferStart: sdaNext = (phase < 2'(`BIT_PHASES / 2));
			camCfgPkg::xferShift: begin
				sclNext = sclHigh;
				sdaNext = shiftReg[31];
			end
			camCfgPkg::xferAck: sclNext = sclHigh; // released, ack not checked
			camCfgPkg::xferStop: begin
				sclNext = (phase != 2'd0);
				sdaNext = (phase >= 2'(`BIT_PHASES / 2));
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			sclOut <= 1'b1;
			sdaOut <= 1'b1;
		end else begin
			sclOut <= sclNext;
			sdaOut <= sdaNext;
		end
	end

endmodule

//--- initScript.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module initScript (
	input  logic                    CLK_400K,
	input  logic                    RESET_N,
	input  camCfgPkg::scriptIndex_t scriptIndex,
	output camCfgPkg::scriptEntry_t scriptEntry
);

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			scriptEntry <= '0;
		end else begin
			case (scriptIndex)
				5'd0:  scriptEntry <= {`CAM_I2C_ADDR, 16'h0103, 8'h01}; // software reset
				5'd1:  scriptEntry <= {`DELAY_TAG, 16'h0000, 8'd10};
				5'd2:  scriptEntry <= {`CAM_I2C_ADDR, 16'h0100, 8'h00}; // standby
				5'd3:  scriptEntry <= {`CAM_I2C_ADDR, 16'h0302, 8'h18}; // pll1 multiplier
				5'd4:  scriptEntry <= {`CAM_I2C_ADDR, 16'h0303, 8'h00};
				5'd5:  scriptEntry <= {`CAM_I2C_ADDR, 16'h0304, 8'h03}; // mipi divider
				// 800x480 output
				5'd6:  scriptEntry <= {`CAM_I2C_ADDR, 16'h3808, 8'h03};
				5'd7:  scriptEntry <= {`CAM_I2C_ADDR, 16'h3809, 8'h20};
				5'd8:  scriptEntry <= {`CAM_I2C_ADDR, 16'h380A, 8'h01};
				5'd9:  scriptEntry <= {`CAM_I2C_ADDR, 16'h380B, 8'hE0};
				5'd10: scriptEntry <= {`DELAY_TAG, 16'h0000, 8'd10};
				// manual white balance gains
				5'd11: scriptEntry <= {`CAM_I2C_ADDR, 16'h5018, 8'(`RED_GAIN >> 6)};
				5'd12: begin
					scriptEntry <= {`CAM_I2C_ADDR, 16'h5019, 2'b00, 6'(`RED_GAIN)};
				end
				5'd13: scriptEntry <= {`CAM_I2C_ADDR, 16'h501A, 8'(`GREEN_GAIN >> 6)};
				5'd14: begin
					scriptEntry <= {`CAM_I2C_ADDR, 16'h501B, 2'b00, 6'(`GREEN_GAIN)};
				end
				5'd15: scriptEntry <= {`CAM_I2C_ADDR, 16'h501C, 8'(`BLUE_GAIN >> 6)};
				5'd16: begin
					scriptEntry <= {`CAM_I2C_ADDR, 16'h501D, 2'b00, 6'(`BLUE_GAIN)};
				end
				5'd17: scriptEntry <= {`CAM_I2C_ADDR, 16'h0100, 8'h01}; // streaming on
				default: scriptEntry <= '0; // past the end
			endcase
		end
	end

endmodule

//--- mipiCameraConfig.sv
`timescale 1ns/1ns

module mipiCameraConfig (
	input  logic                CLK_400K,
	input  logic                RESET_N,
	inout  wire                 i2cSda,
	output logic                i2cScl,
	output camCfgPkg::regData_t sensorId,
	output logic                cameraReleased
);

	logic                    writeStart;
	camCfgPkg::slaveAddr_t   writeSlave;
	camCfgPkg::regAddr_t     writeReg;
	camCfgPkg::regData_t     writeData;
	logic [1:0]              writeByteCount;
	logic                    writeDone;
	logic                    readStart;
	camCfgPkg::slaveAddr_t   readSlave;
	logic                    readDone;
	camCfgPkg::regData_t     readData;
	camCfgPkg::scriptIndex_t scriptIndex;
	camCfgPkg::scriptEntry_t scriptEntry;
	logic                    writeScl;
	logic                    writeSda;
	logic                    readScl;
	logic                    readSda;
	logic                    sdaIn;

	assign i2cScl = writeScl & readScl; // push-pull, idle engines sit high
	assign i2cSda = (writeSda & readSda) ? 1'bz : 1'b0; // open drain
	assign sdaIn = i2cSda;

	cameraConfigCtrl ctrl (
		.CLK_400K(CLK_400K), .RESET_N(RESET_N),
		.writeDone(writeDone), .readDone(readDone), .readData(readData),
		.scriptEntry(scriptEntry), .writeStart(writeStart), .writeSlave(writeSlave),
		.writeReg(writeReg), .writeData(writeData), .writeByteCount(writeByteCount),
		.readStart(readStart), .readSlave(readSlave), .scriptIndex(scriptIndex),
		.sensorId(sensorId), .cameraReleased(cameraReleased)
	);

	initScript script (
		.CLK_400K(CLK_400K), .RESET_N(RESET_N),
		.scriptIndex(scriptIndex), .scriptEntry(scriptEntry)
	);

	i2cWriteXfer writeXfer (
		.CLK_400K(CLK_400K), .RESET_N(RESET_N), .writeStart(writeStart),
		.writeSlave(writeSlave), .writeReg(writeReg), .writeData(writeData),
		.writeByteCount(writeByteCount), .sdaIn(sdaIn),
		.sclOut(writeScl), .sdaOut(writeSda), .writeDone(writeDone)
	);

	i2cReadXfer readXfer (
		.CLK_400K(CLK_400K), .RESET_N(RESET_N), .readStart(readStart),
		.readSlave(readSlave), .sdaIn(sdaIn), .sclOut(readScl), .sdaOut(readSda),
		.readDone(readDone), .readData(readData)
	);

endmodule

//--- tbClockGen.sv
`timescale 1ns/1ns

module tbClockGen (
	output logic CLK_400K,
	output logic RESET_N
);

	initial begin
		CLK_400K = 1'b0;
		forever #10 CLK_400K = ~CLK_400K; // 20 ns period
	end

	initial begin
		RESET_N = 1'b0;
		repeat (16) @(posedge CLK_400K);
		@(negedge CLK_400K);
		RESET_N = 1'b1;
	end

endmodule

//--- tbMipiCameraConfig.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module tbMipiCameraConfig;

	localparam int XFER_BUDGET = 200;   // cycles allowed per transfer
	localparam int POST_RELEASE = 100;  // quiet window after release
	localparam int NUM_TESTS = 6;

	logic                    CLK_400K;
	logic                    RESET_N;
	wire                     i2cSda;
	logic                    i2cScl;
	camCfgPkg::regData_t     sensorId;
	logic                    cameraReleased;
	logic [2:0]              wrongAnswers;
	logic                    startSeen;
	logic                    stopSeen;
	logic [1:0]              xferKind;
	camCfgPkg::slaveAddr_t   xferSlave;
	camCfgPkg::regAddr_t     xferReg;
	camCfgPkg::regData_t     xferData;
	camCfgPkg::scriptEntry_t lastWrite;
	logic                    releaseSeen;
	int                      testErrors [1:6];
	int                      cycleCount;
	int                      cycleLimit;
	int                      checkCount;
	int                      failCount;
	int                      readsSeen;
	int                      pointersSeen;
	int                      scriptWrites;
	int                      scriptStarts;
	int                      totalWrites;
	int                      waitChecks;
	int                      waitsExpected;
	int                      lastStopCycle;
	int unsigned             seedDraw;

	pullup (i2cSda);

	tbClockGen clockGen (.CLK_400K(CLK_400K), .RESET_N(RESET_N));

	mipiCameraConfig DUT (
		.CLK_400K(CLK_400K), .RESET_N(RESET_N), .i2cSda(i2cSda), .i2cScl(i2cScl),
		.sensorId(sensorId), .cameraReleased(cameraReleased)
	);

	tbSensorModel sensor (
		.CLK_400K(CLK_400K), .scl(i2cScl), .sda(i2cSda), .wrongAnswers(wrongAnswers),
		.startSeen(startSeen), .stopSeen(stopSeen), .xferKind(xferKind),
		.xferSlave(xferSlave), .xferReg(xferReg), .xferData(xferData)
	);

	// own copy of the init script, {addr, reg, data}
	function automatic camCfgPkg::scriptEntry_t scriptStep(input int idx);
		logic [13:0] gain;
		gain = (idx < 13) ? `RED_GAIN : (idx < 15) ? `GREEN_GAIN : `BLUE_GAIN;
		case (idx)
			0: return {`CAM_I2C_ADDR, 16'h0103, 8'h01};
			1, 10: return {`DELAY_TAG, 16'h0000, 8'd10};
			2: return {`CAM_I2C_ADDR, 16'h0100, 8'h00};
			3: return {`CAM_I2C_ADDR, 16'h0302, 8'h18};
			4: return {`CAM_I2C_ADDR, 16'h0303, 8'h00};
			5: return {`CAM_I2C_ADDR, 16'h0304, 8'h03};
			6: return {`CAM_I2C_ADDR, 16'h3808, 8'h03};
			7: return {`CAM_I2C_ADDR, 16'h3809, 8'h20};
			8: return {`CAM_I2C_ADDR, 16'h380A, 8'h01};
			9: return {`CAM_I2C_ADDR, 16'h380B, 8'hE0};
			11, 13, 15: return {`CAM_I2C_ADDR, 16'h5018 + 16'(idx - 11), gain[13:6]};
			12, 14, 16: return {`CAM_I2C_ADDR, 16'h5018 + 16'(idx - 11), 2'b00, gain[5:0]};
			17: return {`CAM_I2C_ADDR, 16'h0100, 8'h01};
			default: return '0;
		endcase
	endfunction

	// n-th entry that is a real write
	function automatic camCfgPkg::scriptEntry_t expectedWrites(input int n);
		camCfgPkg::scriptEntry_t entry;
		int seen;
		seen = 0;
		for (int i = 0; i < `SCRIPT_LEN; i++) begin
			entry = scriptStep(i);
			if (entry[31:24] != `DELAY_TAG) begin
				if (seen == n) begin
					return entry;
				end
				seen++;
			end
		end
		return '0;
	endfunction

	// wait cycles directly before the n-th write
	function automatic int waitBeforeWrite(input int n);
		camCfgPkg::scriptEntry_t entry;
		int seen;
		int pending;
		seen = 0;
		pending = 0;
		for (int i = 0; i < `SCRIPT_LEN; i++) begin
			entry = scriptStep(i);
			if (entry[31:24] == `DELAY_TAG) begin
				pending += entry[7:0];
			end else begin
				if (seen == n) begin
					return pending;
				end
				seen++;
				pending = 0;
			end
		end
		return 0;
	endfunction

	task automatic checkRegWrite(input int test, input string what,
			input camCfgPkg::slaveAddr_t gotSlave, input camCfgPkg::regAddr_t gotReg,
			input camCfgPkg::regData_t gotData, input camCfgPkg::slaveAddr_t expSlave,
			input camCfgPkg::regAddr_t expReg, input camCfgPkg::regData_t expData);
		checkCount++;
		if (gotSlave !== expSlave || gotReg !== expReg || gotData !== expData) begin
			$display("mismatch at %0t: test %0d %s got %h/%h/%h, expected %h/%h/%h",
				$time, test, what, gotSlave, gotReg, gotData, expSlave, expReg, expData);
			testErrors[test]++;
			failCount++;
		end
	endtask

	task automatic checkId(input int test, input string what,
			input camCfgPkg::regData_t got, input camCfgPkg::regData_t exp);
		checkCount++;
		if (got !== exp) begin
			$display("mismatch at %0t: test %0d %s got %h, expected %h",
				$time, test, what, got, exp);
			testErrors[test]++;
			failCount++;
		end
	endtask

	task automatic checkLevel(input int test, input string what, input logic got,
			input logic exp);
		checkCount++;
		if (got !== exp) begin
			$display("mismatch at %0t: test %0d %s got %b, expected %b",
				$time, test, what, got, exp);
			testErrors[test]++;
			failCount++;
		end
	endtask

	task automatic reportFailure(input int test, input string what);
		$display("error at %0t: test %0d %s", $time, test, what);
		testErrors[test]++;
		failCount++;
	endtask

	task automatic reportTest(input int test, input string name);
		$display("test %0d %s: %s", test, name, (testErrors[test] == 0) ? "passed" : "failed");
	endtask

	// one transfer finished on the bus
	task automatic logTransfer();
		camCfgPkg::regData_t     servedId;
		camCfgPkg::scriptEntry_t exp;
		case (xferKind)
			2'd0: begin
				checkRegWrite(2, "pointer write", xferSlave, xferReg, xferData,
					`CAM_I2C_ADDR, `CAM_ID_REG, 8'h00);
				checkLevel(3, "pointer write before script", scriptWrites == 0, 1'b1);
				pointersSeen++;
			end
			2'd2: begin
				servedId = (readsSeen < wrongAnswers) ? 8'h00 : `CAM_EXPECTED_ID;
				checkLevel(2, "pointer write precedes read", pointersSeen == readsSeen + 1, 1'b1);
				checkRegWrite(2, "ID read", xferSlave, xferReg, xferData,
					`CAM_I2C_ADDR | 8'h01, 16'h0000, servedId);
				readsSeen++;
			end
			default: begin
				exp = expectedWrites(scriptWrites);
				checkLevel(3, "script write after good ID", readsSeen == wrongAnswers + 1, 1'b1);
				checkRegWrite(4, "script write", xferSlave, xferReg, xferData,
					exp[31:24], exp[23:8], exp[7:0]);
				lastWrite = {xferSlave, xferReg, xferData};
				scriptWrites++;
			end
		endcase
	endtask

	// bus events, sampled on the rising edge
	always @(posedge CLK_400K) begin
		if (RESET_N) begin
			cycleCount++;
			if (startSeen) begin
				if (releaseSeen) begin
					reportFailure(6, "bus activity started after release");
				end else if (readsSeen >= wrongAnswers + 1) begin
					if (waitBeforeWrite(scriptStarts) > 0) begin
						checkLevel(5, "idle before write covers wait",
							cycleCount - lastStopCycle >= waitBeforeWrite(scriptStarts), 1'b1);
						waitChecks++;
					end
					scriptStarts++;
				end
			end
			if (stopSeen) begin
				lastStopCycle = cycleCount;
				logTransfer();
			end
			if (cameraReleased === 1'b1 && !releaseSeen) begin
				releaseSeen = 1'b1;
				checkLevel(6, "release after all writes", scriptWrites == totalWrites, 1'b1);
				checkRegWrite(6, "write before release", lastWrite[31:24], lastWrite[23:8],
					lastWrite[7:0], `CAM_I2C_ADDR, 16'h0100, 8'h01);
			end else if (cameraReleased !== 1'b1 && releaseSeen) begin
				reportFailure(6, "release level dropped");
			end
		end
	end

	// run limit from transfer budget, waits and retries
	initial begin
		int waitTotal;
		waitTotal = 0;
		for (int n = 0; n < `SCRIPT_LEN; n++) begin
			waitTotal += waitBeforeWrite(n);
		end
		cycleLimit = 2 * (20 * XFER_BUDGET + waitTotal + 4 * XFER_BUDGET);
		@(posedge RESET_N);
		while (cycleCount < cycleLimit) begin
			@(posedge CLK_400K);
		end
		$display("run stopped: no release within %0d cycles", cycleLimit);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		seedDraw = $urandom(96477);
		wrongAnswers = 3'($urandom % 4);
		cycleCount = 0;
		checkCount = 0;
		failCount = 0;
		readsSeen = 0;
		pointersSeen = 0;
		scriptWrites = 0;
		scriptStarts = 0;
		waitChecks = 0;
		lastStopCycle = 0;
		lastWrite = '0;
		releaseSeen = 1'b0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			testErrors[t] = 0;
		end
		totalWrites = 0;
		for (int i = 0; i < `SCRIPT_LEN; i++) begin
			if (scriptStep(i) >> 24 != `DELAY_TAG) begin
				totalWrites++;
			end
		end
		waitsExpected = 0;
		for (int n = 0; n < totalWrites; n++) begin
			if (waitBeforeWrite(n) > 0) begin
				waitsExpected++;
			end
		end

		@(posedge RESET_N);
		checkLevel(1, "SCL idle", i2cScl, 1'b1);
		checkLevel(1, "SDA released", i2cSda, 1'b1);
		checkLevel(1, "release level", cameraReleased, 1'b0);
		checkId(1, "sensor ID", sensorId, 8'h00);
		reportTest(1, "reset state");

		@(posedge cameraReleased);
		repeat (POST_RELEASE) @(posedge CLK_400K);
		checkId(2, "final sensor ID", sensorId, `CAM_EXPECTED_ID);
		reportTest(2, "ID read sequence");
		checkLevel(3, "reads before script", readsSeen == wrongAnswers + 1, 1'b1);
		reportTest(3, "ID retries");
		checkLevel(4, "all script writes logged", scriptWrites == totalWrites, 1'b1);
		reportTest(4, "script writes");
		checkLevel(5, "every wait measured", waitChecks == waitsExpected, 1'b1);
		reportTest(5, "wait entries");
		checkLevel(6, "release level held", cameraReleased, 1'b1);
		reportTest(6, "release");

		$display("%0d checks, %0d failed, %0d wrong ID answers", checkCount, failCount,
			wrongAnswers);
		if (failCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tbSensorModel.sv
`timescale 1ns/1ns
`include "camCfg_macros.svh"

module tbSensorModel (
	input  logic                  CLK_400K,
	input  logic                  scl,
	inout  wire                   sda,
	input  logic [2:0]            wrongAnswers, // reads that answer 0x00 first
	output logic                  startSeen,
	output logic                  stopSeen,
	output logic [1:0]            xferKind,     // 0 pointer, 1 register write, 2 read
	output camCfgPkg::slaveAddr_t xferSlave,
	output camCfgPkg::regAddr_t   xferReg,
	output camCfgPkg::regData_t   xferData
);

	logic       sclPrev;
	logic       sdaPrev;
	logic       driveLow;
	logic [7:0] shiftIn;
	logic [7:0] txByte;
	logic [7:0] rxBytes [0:3];
	logic       inAck;
	logic       txMode;
	logic       isRead;
	int         bitCount;
	int         byteCount;
	int         txBit;
	int         readCount;

	assign sda = driveLow ? 1'b0 : 1'bz;

	initial begin
		sclPrev = 1'b1;
		sdaPrev = 1'b1;
		driveLow = 1'b0;
		inAck = 1'b0;
		txMode = 1'b0;
		isRead = 1'b0;
		bitCount = 0;
		byteCount = 0;
		readCount = 0;
		startSeen = 1'b0;
		stopSeen = 1'b0;
		xferKind = 2'd0;
		xferSlave = '0;
		xferReg = '0;
		xferData = '0;
	end

	// bus lines oversampled on the clock, edges found between samples
	always @(negedge CLK_400K) begin
		startSeen <= 1'b0;
		stopSeen <= 1'b0;
		if (sclPrev === 1'b1 && scl === 1'b1 && sdaPrev === 1'b1 && sda === 1'b0) begin
			startSeen <= 1'b1;
			bitCount = 0;
			byteCount = 0;
			inAck = 1'b0;
			txMode = 1'b0;
			isRead = 1'b0;
		end else if (sclPrev === 1'b1 && scl === 1'b1 && sdaPrev === 1'b0 && sda === 1'b1) begin
			stopSeen <= 1'b1;
			driveLow <= 1'b0;
			xferSlave <= rxBytes[0];
			xferReg <= {rxBytes[1], rxBytes[2]};
			if (isRead) begin
				xferKind <= 2'd2;
				xferReg <= '0;
				xferData <= txByte; // the ID that was served
				readCount = readCount + 1;
			end else if (byteCount == 3) begin
				xferKind <= 2'd0;
				xferData <= '0;
			end else begin
				xferKind <= 2'd1;
				xferData <= rxBytes[3];
			end
		end else if (sclPrev === 1'b0 && scl === 1'b1) begin
			if (!inAck && !txMode && !(isRead && byteCount > 0)) begin
				shiftIn = {shiftIn[6:0], sda};
				bitCount = bitCount + 1;
			end
		end else if (sclPrev === 1'b1 && scl === 1'b0) begin
			if (inAck) begin
				inAck = 1'b0;
				bitCount = 0;
				if (isRead && byteCount == 1) begin
					txByte = (readCount < wrongAnswers) ? 8'h00 : `CAM_EXPECTED_ID;
					txMode = 1'b1;
					txBit = 1;
					driveLow <= !txByte[7];
				end else begin
					driveLow <= 1'b0;
				end
			end else if (txMode) begin
				if (txBit < 8) begin
					driveLow <= !txByte[7 - txBit];
					txBit = txBit + 1;
				end else begin
					driveLow <= 1'b0; // master answers with nack
					txMode = 1'b0;
				end
			end else if (bitCount == 8 && byteCount < 4) begin
				rxBytes[byteCount] = shiftIn;
				if (byteCount == 0) begin
					isRead = shiftIn[0];
				end
				byteCount = byteCount + 1;
				inAck = 1'b1;
				driveLow <= 1'b1; // ack every byte
			end
		end
		sclPrev = scl;
		sdaPrev = sda;
	end

endmodule
